// File: Makefile
TOP      ?= tb_victim_buffer
FLIST    ?= flist.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --timing --assert
VERILATOR ?= verilator
PASS_MSG := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+include
source/wb_pkg.sv
source/slot_bus_if.sv
source/victim_slot.sv
source/victim_alloc.sv
source/victim_drain.sv
source/snoop_responder.sv
source/victim_buffer_top.sv
tests/clk_gen.sv
tests/victim_buffer_assert.sv
tests/tb_victim_buffer.sv

// File: include/wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

`define WB_SLOTS 4
`define WB_SLOT_W 2

`define WB_BEATS 4
`define WB_BEAT_BITS 64

`define WB_LINE_ADDR_BITS 26
`define WB_OFFSET_BITS 6

`define WB_IDS 2
`define WB_ID_W 1

`endif

// File: source/slot_bus_if.sv
`timescale 1ns/1ps

interface slot_bus_if;
    import wb_pkg::*;

    logic reserve;
    logic fill_en;
    slot_idx_t fill_idx;
    logic fill_present;
    line_addr_t fill_addr;
    line_data_t fill_data;
    logic fill_dirty;
    line_addr_t store_addr;

    logic launch;
    logic release_en;

    line_addr_t snoop_addr;
    logic snoop_clean; // Already qualified with the snoop request.

    logic busy;
    logic ready;
    logic present;
    line_addr_t addr;
    line_data_t data;
    logic dirty;
    logic store_hit;
    logic snoop_hit;

    modport slot (
        input reserve, fill_en, fill_idx, fill_present, fill_addr, fill_data, fill_dirty,
        input store_addr, launch, release_en, snoop_addr, snoop_clean,
        output busy, ready, present, addr, data, dirty, store_hit, snoop_hit
    );
    modport alloc (
        output reserve, fill_en, fill_idx, fill_present, fill_addr, fill_data, fill_dirty,
        output store_addr,
        input busy, store_hit
    );
    modport drain (
        output launch, release_en,
        input ready, present, addr, data, dirty, snoop_clean, snoop_hit
    );
    modport snoop (
        output snoop_addr, snoop_clean,
        input snoop_hit, data, dirty
    );
endinterface

// File: source/snoop_responder.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module snoop_responder (
    input  logic               clk,
    input  logic               rst,
    slot_bus_if.snoop          slots [`WB_SLOTS],
    input  logic               snoop_en,
    input  logic               snoop_clean,
    input  wb_pkg::line_addr_t snoop_addr,
    input  logic               fill_en,
    input  wb_pkg::line_addr_t fill_addr,
    input  wb_pkg::line_data_t fill_data,
    input  logic               fill_dirty,
    output logic               snoop_hit,
    output wb_pkg::line_data_t snoop_data,
    output logic               snoop_dirty
);
    import wb_pkg::*;

    logic [`WB_SLOTS-1:0] hit_v;
    line_data_t data_v [`WB_SLOTS];
    logic [`WB_SLOTS-1:0] dirty_v;
    line_data_t hit_data;
    logic hit_dirty;
    logic fill_hit;

    for (genvar i = 0; i < `WB_SLOTS; i++) begin : g_slot
        assign slots[i].snoop_addr = snoop_addr;
        assign slots[i].snoop_clean = snoop_en && snoop_clean;
        assign hit_v[i] = slots[i].snoop_hit;
        assign data_v[i] = slots[i].data;
        assign dirty_v[i] = slots[i].dirty;
    end

    // At most one slot holds a line, so the hits are one-hot.
    always_comb begin
        hit_data = '0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            if (hit_v[i]) hit_data = hit_data | data_v[i];
        end
    end

    assign hit_dirty = |(hit_v & dirty_v);
    assign fill_hit = fill_en && (fill_addr == snoop_addr); // Fill in flight wins.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) snoop_hit <= 1'b0;
        else if (snoop_en) snoop_hit <= (|hit_v) || fill_hit;
    end

    always_ff @(posedge clk) begin
        if (snoop_en) begin
            snoop_data <= fill_hit ? fill_data : hit_data;
            snoop_dirty <= fill_hit ? fill_dirty : hit_dirty;
        end
    end
endmodule

// File: source/victim_alloc.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module victim_alloc (
    input  logic               clk,
    input  logic               rst,
    slot_bus_if.alloc          slots [`WB_SLOTS],
    input  logic               alloc_en,
    input  wb_pkg::line_addr_t store_addr,
    output wb_pkg::slot_idx_t  alloc_idx,
    output logic               store_hit,
    output logic               full,
    input  logic               fill_en,
    input  wb_pkg::slot_idx_t  fill_idx,
    input  logic               fill_present,
    input  wb_pkg::line_addr_t fill_addr,
    input  wb_pkg::line_data_t fill_data,
    input  logic               fill_dirty
);
    import wb_pkg::*;

    logic [`WB_SLOTS-1:0] busy_v;
    logic [`WB_SLOTS-1:0] hit_v;
    slot_idx_t free_idx;
    slot_idx_t hit_idx;
    logic lookup_hit;
    logic all_busy;
    logic alloc_go;

    assign lookup_hit = |hit_v;
    assign all_busy = &busy_v;
    assign alloc_go = alloc_en && !lookup_hit && !all_busy;

    always_comb begin
        free_idx = '0;
        hit_idx = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (!busy_v[i]) free_idx = slot_idx_t'(i); // Lowest free wins.
        end
        for (int i = 0; i < `WB_SLOTS; i++) begin
            if (hit_v[i]) hit_idx = slot_idx_t'(i);
        end
    end

    for (genvar i = 0; i < `WB_SLOTS; i++) begin : g_slot
        assign busy_v[i] = slots[i].busy;
        assign hit_v[i] = slots[i].store_hit;
        assign slots[i].reserve = alloc_go && (free_idx == slot_idx_t'(i));
        assign slots[i].fill_en = fill_en;
        assign slots[i].fill_idx = fill_idx;
        assign slots[i].fill_present = fill_present;
        assign slots[i].fill_addr = fill_addr;
        assign slots[i].fill_data = fill_data;
        assign slots[i].fill_dirty = fill_dirty;
        assign slots[i].store_addr = store_addr;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alloc_idx <= '0;
            store_hit <= 1'b0;
            full <= 1'b0;
        end else begin
            alloc_idx <= lookup_hit ? hit_idx : free_idx;
            store_hit <= lookup_hit;
            full <= all_busy;
        end
    end
endmodule

// File: source/victim_buffer_top.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module victim_buffer_top (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          alloc_en,
    input  wb_pkg::line_addr_t                            store_addr,
    output wb_pkg::slot_idx_t                             alloc_idx,
    output logic                                          store_hit,
    output logic                                          full,
    input  logic                                          fill_en,
    input  wb_pkg::slot_idx_t                             fill_idx,
    input  logic                                          fill_present,
    input  wb_pkg::line_addr_t                            fill_addr,
    input  wb_pkg::line_data_t                            fill_data,
    input  logic                                          fill_dirty,
    input  logic                                          snoop_en,
    input  logic                                          snoop_clean,
    input  wb_pkg::line_addr_t                            snoop_addr,
    output logic                                          snoop_hit,
    output wb_pkg::line_data_t                            snoop_data,
    output logic                                          snoop_dirty,
    output logic                                          aw_valid,
    input  logic                                          aw_ready,
    output wb_pkg::wr_id_t                                aw_id,
    output logic [`WB_LINE_ADDR_BITS+`WB_OFFSET_BITS-1:0] aw_addr,
    output wb_pkg::wb_op_t                                aw_op,
    output logic                                          w_valid,
    input  logic                                          w_ready,
    output logic [`WB_BEAT_BITS-1:0]                      w_data,
    output logic                                          w_last,
    input  logic                                          b_valid,
    input  wb_pkg::wr_id_t                                b_id
);
    import wb_pkg::*;

    slot_bus_if slot_bus [`WB_SLOTS] ();

    for (genvar i = 0; i < `WB_SLOTS; i++) begin : g_slot
        victim_slot victim_slot_i (
            .clk(clk), .rst(rst), .bus(slot_bus[i]), .slot_idx(slot_idx_t'(i))
        );
    end

    victim_alloc victim_alloc_i (
        .clk(clk), .rst(rst), .slots(slot_bus),
        .alloc_en(alloc_en), .store_addr(store_addr), .alloc_idx(alloc_idx),
        .store_hit(store_hit), .full(full),
        .fill_en(fill_en), .fill_idx(fill_idx), .fill_present(fill_present),
        .fill_addr(fill_addr), .fill_data(fill_data), .fill_dirty(fill_dirty)
    );

    victim_drain victim_drain_i (
        .clk(clk), .rst(rst), .slots(slot_bus),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_id(aw_id), .aw_addr(aw_addr),
        .aw_op(aw_op), .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data),
        .w_last(w_last), .b_valid(b_valid), .b_id(b_id)
    );

    snoop_responder snoop_responder_i (
        .clk(clk), .rst(rst), .slots(slot_bus),
        .snoop_en(snoop_en), .snoop_clean(snoop_clean), .snoop_addr(snoop_addr),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data),
        .fill_dirty(fill_dirty), .snoop_hit(snoop_hit), .snoop_data(snoop_data),
        .snoop_dirty(snoop_dirty)
    );
endmodule

// File: source/victim_drain.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module victim_drain (
    input  logic                                             clk,
    input  logic                                             rst,
    slot_bus_if.drain                                        slots [`WB_SLOTS],
    output logic                                             aw_valid,
    input  logic                                             aw_ready,
    output wb_pkg::wr_id_t                                   aw_id,
    output logic [`WB_LINE_ADDR_BITS+`WB_OFFSET_BITS-1:0]    aw_addr,
    output wb_pkg::wb_op_t                                   aw_op,
    output logic                                             w_valid,
    input  logic                                             w_ready,
    output logic [`WB_BEAT_BITS-1:0]                         w_data,
    output logic                                             w_last,
    input  logic                                             b_valid,
    input  wb_pkg::wr_id_t                                   b_id
);
    import wb_pkg::*;

    localparam int BEAT_W = $clog2(`WB_BEATS);

    typedef enum logic [1:0] {IDLE, ADDRESS, WRITE, WAIT_B} drain_state_t;

    drain_state_t state;
    logic [`WB_SLOTS-1:0] ready_v, present_v, dirty_v, snoop_rel;
    line_addr_t addr_v [`WB_SLOTS];
    line_data_t data_v [`WB_SLOTS];
    slot_idx_t last_idx, sel_idx, cand, proc_idx;
    logic sel_found, go, drop_q;
    logic [`WB_IDS-1:0] id_busy, map_valid;
    slot_idx_t id_map [`WB_IDS];
    wr_id_t free_id;
    logic id_free_any;
    line_addr_t line_addr_q;
    line_data_t line_data_q;
    logic [BEAT_W-1:0] beat;

    always_comb begin
        sel_found = 1'b0;
        sel_idx = last_idx;
        cand = last_idx;
        for (int k = 1; k <= `WB_SLOTS; k++) begin
            cand = slot_idx_t'(last_idx + k); // Round-robin from the last launch.
            if (!sel_found && ready_v[cand]) begin
                sel_found = 1'b1;
                sel_idx = cand;
            end
        end
        free_id = '0;
        for (int j = `WB_IDS - 1; j >= 0; j--) begin
            if (!id_busy[j]) free_id = wr_id_t'(j);
        end
    end

    assign id_free_any = !(&id_busy);
    // A line being cleaned by a snoop this cycle is not started.
    assign go = (state == IDLE) && sel_found && id_free_any && !snoop_rel[sel_idx];

    for (genvar i = 0; i < `WB_SLOTS; i++) begin : g_slot
        assign ready_v[i] = slots[i].ready;
        assign present_v[i] = slots[i].present;
        assign dirty_v[i] = slots[i].dirty;
        assign addr_v[i] = slots[i].addr;
        assign data_v[i] = slots[i].data;
        assign snoop_rel[i] = slots[i].snoop_clean && slots[i].snoop_hit;
        assign slots[i].launch = go && (sel_idx == slot_idx_t'(i));
        assign slots[i].release_en = (drop_q && (proc_idx == slot_idx_t'(i))) ||
            (b_valid && map_valid[b_id] && (id_map[b_id] == slot_idx_t'(i)));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            w_last <= 1'b0;
            beat <= '0;
            drop_q <= 1'b0;
            last_idx <= slot_idx_t'(`WB_SLOTS - 1);
            id_busy <= '0;
            map_valid <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        last_idx <= sel_idx;
                        if (present_v[sel_idx]) begin
                            state <= ADDRESS;
                            aw_valid <= 1'b1;
                            id_busy[free_id] <= 1'b1;
                            map_valid[free_id] <= 1'b1;
                        end else begin
                            state <= WAIT_B;
                            drop_q <= 1'b1; // No line, so just free the slot.
                        end
                    end
                end
                ADDRESS: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        w_valid <= 1'b1;
                        beat <= '0;
                        w_last <= (`WB_BEATS == 1);
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (w_ready) begin
                        beat <= beat + 1'b1;
                        w_last <= (beat == BEAT_W'(`WB_BEATS - 2));
                        if (w_last) begin
                            w_valid <= 1'b0;
                            w_last <= 1'b0;
                            state <= WAIT_B;
                        end
                    end
                end
                default: begin
                    drop_q <= 1'b0;
                    state <= IDLE;
                end
            endcase
            if (b_valid) begin
                id_busy[b_id] <= 1'b0;
                map_valid[b_id] <= 1'b0;
            end
            for (int j = 0; j < `WB_IDS; j++) begin
                if (map_valid[j] && snoop_rel[id_map[j]]) map_valid[j] <= 1'b0;
            end
        end
    end

    // Local copy of the line, so a snoop cannot disturb a burst.
    always_ff @(posedge clk) begin
        if (go) begin
            proc_idx <= sel_idx;
            line_addr_q <= addr_v[sel_idx];
            line_data_q <= data_v[sel_idx];
            aw_op <= dirty_v[sel_idx] ? OP_WRITE_CLEAN : OP_WRITE_EVICT;
            aw_id <= free_id;
            id_map[free_id] <= sel_idx;
        end
    end

    assign aw_addr = {line_addr_q, {`WB_OFFSET_BITS{1'b0}}};
    assign w_data = line_data_q[beat];
endmodule

// File: source/victim_slot.sv
`timescale 1ns/1ps

module victim_slot (
    input  logic              clk,
    input  logic              rst,
    slot_bus_if.slot          bus,
    input  wb_pkg::slot_idx_t slot_idx
);
    import wb_pkg::*;

    logic busy;
    logic filled;
    logic launched;
    logic present;
    line_addr_t addr;
    line_data_t data;
    logic dirty;
    logic fill_hit;
    logic snoop_rel;

    assign fill_hit = bus.fill_en && (bus.fill_idx == slot_idx);
    assign snoop_rel = bus.snoop_clean && bus.snoop_hit; // Snooper takes the line.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            filled <= 1'b0;
            launched <= 1'b0;
            present <= 1'b0;
        end else begin
            if (bus.reserve) begin
                busy <= 1'b1;
                filled <= 1'b0;
                launched <= 1'b0;
                present <= 1'b0;
            end
            if (fill_hit) begin
                filled <= 1'b1;
                present <= bus.fill_present;
            end
            if (bus.launch) launched <= 1'b1;
            if (bus.release_en || snoop_rel) begin
                busy <= 1'b0;
                present <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_hit) begin
            addr <= bus.fill_addr;
            data <= bus.fill_data;
            dirty <= bus.fill_dirty;
        end
    end

    assign bus.busy = busy;
    assign bus.ready = busy && filled && !launched;
    assign bus.present = present;
    assign bus.addr = addr;
    assign bus.data = data;
    assign bus.dirty = dirty;

    // Only a buffered line can match.
    assign bus.store_hit = busy && present && (addr == bus.store_addr);
    assign bus.snoop_hit = busy && present && (addr == bus.snoop_addr);
endmodule

// File: source/wb_pkg.sv
`include "wb_defines.svh"

package wb_pkg;

    // Cache line address without the byte offset.
    typedef logic [`WB_LINE_ADDR_BITS-1:0] line_addr_t;

    typedef logic [`WB_BEATS-1:0][`WB_BEAT_BITS-1:0] line_data_t; // Beat 0 goes out first.

    typedef logic [`WB_SLOT_W-1:0] slot_idx_t;

    typedef logic [`WB_ID_W-1:0] wr_id_t;

    // Dirty lines are written clean and clean lines only evicted.
    typedef enum logic {
        OP_WRITE_CLEAN = 1'b0,
        OP_WRITE_EVICT = 1'b1
    } wb_op_t;

endpackage

// File: tests/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
    end
endmodule

// File: tests/tb_victim_buffer.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module tb_victim_buffer;
    import wb_pkg::*;

    typedef struct packed {line_addr_t addr; line_data_t data; logic dirty;} line_rec_t;
    typedef struct packed {logic [31:0] addr; wb_op_t op; line_data_t beats; wr_id_t id;} burst_t;

    logic clk, rst;
    logic alloc_en, store_hit, full, fill_en, fill_present, fill_dirty;
    line_addr_t store_addr, fill_addr, snoop_addr;
    slot_idx_t alloc_idx, fill_idx;
    line_data_t fill_data, snoop_data;
    logic snoop_en, snoop_clean, snoop_hit, snoop_dirty;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid;
    wr_id_t aw_id, b_id;
    logic [31:0] aw_addr;
    wb_op_t aw_op;
    logic [63:0] w_data;

    line_rec_t lines [line_addr_t];
    bit wanted [line_addr_t];
    int write_cnt [line_addr_t];
    burst_t bursts [$];
    wr_id_t b_todo [$];
    bit id_out [`WB_IDS]; // IDs waiting for their response.
    int errors = 0, pending = 0, beat_no = 0, seq = 0, n_bursts = 0, b_wait = 0;
    bit hold_aw = 0, random_mode = 0;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    victim_buffer_top victim_buffer_top_i (.*);

    bind victim_buffer_top victim_buffer_assert victim_buffer_assert_i (
        .clk(clk), .rst(rst), .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .aw_id(aw_id), .aw_op(aw_op), .w_valid(w_valid), .w_ready(w_ready),
        .w_data(w_data), .w_last(w_last)
    );

    // Expected burst for one line from its address, dirty bit and data.
    function automatic burst_t expect_burst(line_rec_t r);
        burst_t e;
        e.addr = {r.addr, {`WB_OFFSET_BITS{1'b0}}};
        e.op = r.dirty ? OP_WRITE_CLEAN : OP_WRITE_EVICT;
        for (int i = 0; i < `WB_BEATS; i++) e.beats[i] = r.data[i];
        e.id = '0;
        return e;
    endfunction

    task automatic mismatch(string sig, logic [63:0] exp, logic [63:0] got);
        errors++;
        $display("FAIL %0t %s expected %h got %h", $time, sig, exp, got);
    endtask

    task automatic problem(string what);
        errors++;
        $display("ERROR %0t %s", $time, what);
    endtask

    task automatic give_up(string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Memory side ready lines.
    initial begin
        aw_ready = 1'b0;
        w_ready = 1'b0;
        forever begin
            @(posedge clk);
            aw_ready <= hold_aw ? 1'b0 : (random_mode ? ($urandom % 3 != 0) : 1'b1);
            w_ready <= random_mode ? ($urandom % 3 != 0) : 1'b1;
        end
    end

    // One write response per finished burst after a random delay.
    initial begin
        b_valid = 1'b0;
        b_id = '0;
        forever begin
            @(posedge clk);
            b_valid <= 1'b0;
            if (b_todo.size() > 0) begin
                if (b_wait == 0) begin
                    b_valid <= 1'b1;
                    b_id <= b_todo.pop_front();
                    b_wait = random_mode ? int'($urandom % 6) : 0;
                end else b_wait--;
            end
        end
    end

    // Compares every address transfer and data beat.
    always @(posedge clk) begin
        if (rst && aw_valid && aw_ready) begin
            if (id_out[aw_id]) problem("write ID reused before its response came back");
            id_out[aw_id] = 1'b1;
            if (!lines.exists(aw_addr[31:`WB_OFFSET_BITS])) begin
                problem("address transfer for a line that was never filled");
            end else begin
                burst_t e;
                e = expect_burst(lines[aw_addr[31:`WB_OFFSET_BITS]]);
                if (aw_addr !== e.addr) mismatch("aw_addr", e.addr, aw_addr);
                if (aw_op !== e.op) mismatch("aw_op", e.op, aw_op);
                e.id = aw_id;
                bursts.push_back(e);
            end
        end
        if (rst && w_valid && w_ready) begin
            if (bursts.size() == 0) begin
                problem("data beat without an address transfer");
            end else begin
                if (w_data !== bursts[0].beats[beat_no]) begin
                    mismatch("w_data", bursts[0].beats[beat_no], w_data);
                end
                if (w_last !== (beat_no == `WB_BEATS - 1)) begin
                    mismatch("w_last", beat_no == `WB_BEATS - 1, w_last);
                end
                if (beat_no == `WB_BEATS - 1) begin
                    write_cnt[bursts[0].addr[31:`WB_OFFSET_BITS]]++;
                    if (wanted[bursts[0].addr[31:`WB_OFFSET_BITS]]) pending--;
                    b_todo.push_back(bursts[0].id);
                    void'(bursts.pop_front());
                    n_bursts++;
                    beat_no = 0;
                end else beat_no++;
            end
        end
        if (rst && b_valid) id_out[b_id] = 1'b0;
    end

    function automatic line_rec_t new_line(logic dirty);
        line_rec_t r;
        seq++;
        r.addr = line_addr_t'((seq << 10) ^ ($urandom & 32'h3ff)); // Unique per line.
        for (int i = 0; i < `WB_BEATS; i++) r.data[i] = {$urandom, $urandom};
        r.dirty = dirty;
        return r;
    endfunction

    task automatic lookup(line_addr_t a, logic en);
        @(posedge clk);
        alloc_en <= en;
        store_addr <= a;
        @(posedge clk);
        alloc_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic fill_line(slot_idx_t idx, line_rec_t r, logic present);
        if (present) begin
            lines[r.addr] = r;
            wanted[r.addr] = 1;
            write_cnt[r.addr] = 0;
            pending++;
        end
        @(posedge clk);
        fill_en <= 1'b1;
        fill_idx <= idx;
        fill_present <= present;
        fill_addr <= r.addr;
        fill_data <= r.data;
        fill_dirty <= r.dirty;
        @(posedge clk);
        fill_en <= 1'b0;
    endtask

    task automatic add_line(line_rec_t r, output slot_idx_t idx);
        int n;
        n = 0;
        lookup(r.addr, 1'b0);
        while (full) begin
            n++;
            if (n > 300) give_up("a free slot");
            lookup(r.addr, 1'b0);
        end
        lookup(r.addr, 1'b1);
        if (store_hit !== 1'b0) mismatch("store_hit", 0, store_hit);
        idx = alloc_idx;
        fill_line(idx, r, 1'b1);
    endtask

    task automatic snoop_check(line_rec_t r, logic clean, logic exp_hit);
        @(posedge clk);
        snoop_en <= 1'b1;
        snoop_clean <= clean;
        snoop_addr <= r.addr;
        @(posedge clk);
        snoop_en <= 1'b0;
        @(negedge clk);
        if (snoop_hit !== exp_hit) mismatch("snoop_hit", exp_hit, snoop_hit);
        if (exp_hit) begin
            for (int i = 0; i < `WB_BEATS; i++) begin
                if (snoop_data[i] !== r.data[i]) mismatch("snoop_data", r.data[i], snoop_data[i]);
            end
            if (snoop_dirty !== r.dirty) mismatch("snoop_dirty", r.dirty, snoop_dirty);
        end
    endtask

    task automatic wait_drained(string what);
        int n;
        n = 0;
        @(negedge clk);
        while (pending > 0 || b_todo.size() > 0 || b_valid) begin
            n++;
            if (n > 3000) give_up(what);
            @(negedge clk);
        end
    endtask

    task automatic end_test(string name, int err_before);
        $display("Test %-12s %s (%0d errors)", name,
            (errors == err_before) ? "done" : "mismatch", errors - err_before);
    endtask

    initial begin
        line_rec_t r [6];
        slot_idx_t idx;
        int e0, n;
        void'($urandom(32'hc9e6_a2eb));
        alloc_en = 0;
        store_addr = '0;
        fill_en = 0;
        fill_idx = '0;
        fill_present = 0;
        fill_addr = '0;
        fill_data = '0;
        fill_dirty = 0;
        snoop_en = 0;
        snoop_clean = 0;
        snoop_addr = '0;
        n = 0;
        while (!rst) begin
            n++;
            if (n > 20) give_up("reset release");
            @(posedge clk);
        end

        e0 = errors; // Dirty and clean eviction.
        for (int i = 0; i < 4; i++) add_line(new_line(i % 2 == 0), idx);
        wait_drained("eviction bursts");
        end_test("eviction", e0);

        e0 = errors; // Store lookup and full with the drain held off.
        hold_aw = 1;
        for (int i = 0; i < 4; i++) begin
            r[i] = new_line(1'b1);
            add_line(r[i], idx);
            if (idx !== slot_idx_t'(i)) mismatch("alloc_idx", i, idx);
        end
        r[4] = new_line(1'b0);
        lookup(r[4].addr, 1'b1);
        if (full !== 1'b1) mismatch("full", 1, full);
        if (store_hit !== 1'b0) mismatch("store_hit", 0, store_hit);
        lookup(r[2].addr, 1'b0);
        if (store_hit !== 1'b1) mismatch("store_hit", 1, store_hit);
        if (alloc_idx !== 2'd2) mismatch("alloc_idx", 2, alloc_idx);
        for (int i = 0; i < 4; i++) begin
            lookup(r[i].addr, 1'b0); // Each line still sits in its own slot.
            if (store_hit !== 1'b1) mismatch("store_hit", 1, store_hit);
            if (alloc_idx !== slot_idx_t'(i)) mismatch("alloc_idx", i, alloc_idx);
        end
        hold_aw = 0;
        wait_drained("bursts after full");
        end_test("lookup_full", e0);

        e0 = errors; // Fill without a line.
        r[0] = new_line(1'b1);
        lookup(r[0].addr, 1'b1);
        if (alloc_idx !== 2'd0) mismatch("alloc_idx", 0, alloc_idx);
        fill_line(2'd0, r[0], 1'b0);
        n = 0;
        lookup(r[0].addr, 1'b0);
        while (alloc_idx !== 2'd0) begin
            n++;
            if (n > 50) give_up("the empty slot to be freed");
            lookup(r[0].addr, 1'b0);
        end
        add_line(new_line(1'b0), idx);
        if (idx !== 2'd0) mismatch("alloc_idx", 0, idx);
        wait_drained("burst after empty fill");
        end_test("not_present", e0);

        e0 = errors; // Snoops on one launched line and one waiting line.
        hold_aw = 1;
        r[0] = new_line(1'b1);
        r[1] = new_line(1'b0);
        add_line(r[0], idx);
        add_line(r[1], idx);
        snoop_check(r[1], 1'b0, 1'b1);
        wanted[r[1].addr] = 0;
        pending--;
        snoop_check(r[1], 1'b1, 1'b1);
        snoop_check(r[0], 1'b0, 1'b1);
        snoop_check(r[0], 1'b1, 1'b1);
        snoop_check(r[1], 1'b0, 1'b0);
        hold_aw = 0;
        wait_drained("launched burst after snoop");
        end_test("snoop", e0);

        e0 = errors; // Random back-pressure.
        random_mode = 1;
        for (int i = 0; i < 16; i++) add_line(new_line($urandom % 2 == 1), idx);
        wait_drained("bursts under back-pressure");
        random_mode = 0;
        end_test("backpressure", e0);

        foreach (lines[a]) begin
            if (write_cnt[a] != (wanted[a] ? 1 : 0)) begin
                mismatch("write count", wanted[a] ? 1 : 0, write_cnt[a]);
            end
        end
        $display("Tests 5, bursts %0d, errors %0d", n_bursts, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

// File: tests/victim_buffer_assert.sv
`timescale 1ns/1ps

module victim_buffer_assert (
    input logic        clk,
    input logic        rst,
    input logic        aw_valid,
    input logic        aw_ready,
    input logic [31:0] aw_addr,
    input logic        aw_id,
    input logic        aw_op,
    input logic        w_valid,
    input logic        w_ready,
    input logic [63:0] w_data,
    input logic        w_last
);
    logic [2:0] w_cnt; // Beats seen in the current burst.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) w_cnt <= '0;
        else if (w_valid && w_ready) w_cnt <= w_last ? 3'd0 : w_cnt + 3'd1;
    end

    aw_stable: assert property (@(posedge clk) disable iff (!rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_id) && $stable(aw_op))
        else $error("aw payload changed while stalled");

    w_stable: assert property (@(posedge clk) disable iff (!rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
        else $error("w payload changed while stalled");

    last_on_fourth: assert property (@(posedge clk) disable iff (!rst)
        w_valid && w_ready |-> (w_last == (w_cnt == 3'd3)))
        else $error("w_last not on the fourth beat");

    reset_quiet: assert property (@(posedge clk) !rst |-> !aw_valid && !w_valid && !w_last)
        else $error("valid high during reset");
endmodule
